/* Makefile */
# Verilator flow for the fetch front end, run from the project root

VERILATOR ?= verilator
TOP       ?= fetch_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= ** PASS **

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# The run passes only if the pass message shows up as a line of its own
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

/* common/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

  // Address and data path width of the core
  localparam int XLEN = 32;

  // Instruction memory holds 64 words, indexed by pc bits 2 and above
  localparam int IMEM_DEPTH = 64;
  localparam int IMEM_AW = $clog2(IMEM_DEPTH);

  // Direct-mapped BTB geometry
  localparam int BTB_ENTRIES = 8;
  localparam int BTB_IW = $clog2(BTB_ENTRIES);

  // Canonical NOP, addi x0,x0,0
  localparam logic [31:0] I_NOP = 32'h0000_0013;

  // First fetch address after reset
  localparam logic [XLEN-1:0] RESET_PC = '0;

  // Prediction attached to one fetch address
  typedef struct packed {
    logic            hit;
    logic            taken;
    logic [XLEN-1:0] target;
  } fetch_pred_t;

  // Redirect from the back end, valid for one cycle
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] target;
  } redirect_t;

  // BTB write request, pc selects the entry and supplies the tag
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] target;
    logic            taken;
  } btb_update_t;

  // Program load port, one word per strobe
  typedef struct packed {
    logic               we;
    logic [IMEM_AW-1:0] addr;
    logic [31:0]        data;
  } imem_load_t;

  // One slot leaving the fetch stage
  typedef struct packed {
    logic            valid;
    logic [31:0]     instr;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pc_plus4;
    fetch_pred_t     pred;
  } fetch_out_t;

endpackage

`default_nettype wire

/* design/btb.sv */
`timescale 1ns/1ps
`default_nettype none

module btb (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [fetch_pkg::XLEN-1:0]  lookup_pc,
  output fetch_pkg::fetch_pred_t      pred,
  input  fetch_pkg::btb_update_t      upd
);
  import fetch_pkg::*;

  // Entry state, valid bits are the only part with a reset
  logic [BTB_ENTRIES-1:0] valid_q;
  logic [XLEN-1:BTB_IW+2] tag_q    [BTB_ENTRIES];
  logic [XLEN-1:0]        target_q [BTB_ENTRIES];
  logic                   taken_q  [BTB_ENTRIES];

  logic [BTB_IW-1:0] lidx;
  logic [BTB_IW-1:0] uidx;
  logic              hit;

  // Index from the bits right above the byte offset
  assign lidx = lookup_pc[BTB_IW+1:2];
  assign uidx = upd.pc[BTB_IW+1:2];

  // Tag covers every pc bit above the index
  assign hit = valid_q[lidx] && (tag_q[lidx] == lookup_pc[XLEN-1:BTB_IW+2]);

  // Combinational lookup, answers pc_next in the same cycle
  always_comb begin
    pred.hit    = hit;
    pred.taken  = hit && taken_q[lidx];
    pred.target = target_q[lidx];
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (upd.valid) begin
      valid_q[uidx] <= 1'b1;
    end
  end

  // New contents show up on lookups from the cycle after the strobe
  always_ff @(posedge clk) begin
    if (upd.valid) begin
      tag_q[uidx]    <= upd.pc[XLEN-1:BTB_IW+2];
      target_q[uidx] <= upd.target;
      taken_q[uidx]  <= upd.taken;
    end
  end

  // The back end must hand over word aligned branch and target addresses
  a_upd_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    upd.valid |-> (upd.target[1:0] == 2'b00) && (upd.pc[1:0] == 2'b00))
    else $error("btb: misaligned update pc %h target %h", upd.pc, upd.target);

endmodule

`default_nettype wire

/* design/fetch_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_ctrl (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        stall,
  input  fetch_pkg::redirect_t        redirect,
  input  fetch_pkg::fetch_pred_t      pred,
  output logic [fetch_pkg::XLEN-1:0]  pc_next,
  output logic                        fetch_en,
  output logic                        flush
);
  import fetch_pkg::*;

  logic            ready;
  logic [XLEN-1:0] pc;
  fetch_pred_t     pred_q;
  logic            started;
  logic            reissue;

  assign ready = !stall;

  // The BRAM keeps reading during reset so the reset PC word is already loaded
  assign fetch_en = !rst_n || ready;

  // A redirect squashes the slot captured on the same edge
  assign flush = redirect.valid;

  // Next fetch address, issued early to the BRAM and the BTB
  // The stage drops the slot captured on the first edge after reset and on a
  // flushed edge, so the address of that slot is issued a second time
  always_comb begin
    if (!ready) begin
      pc_next = pc;
    end else if (redirect.valid) begin
      pc_next = redirect.target;
    end else if (reissue) begin
      pc_next = pc;
    end else if (pred_q.hit && pred_q.taken) begin
      pc_next = pred_q.target;
    end else begin
      pc_next = pc + XLEN'(4);
    end
  end

  // pc is the address issued in the previous fetch cycle
  // pred_q is the BTB answer for that address and steers the next one
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc      <= RESET_PC;
      pred_q  <= '0;
      started <= 1'b0;
      reissue <= 1'b1;
    end else if (fetch_en) begin
      pc      <= pc_next;
      pred_q  <= pred;
      started <= 1'b1;
      // Mirrors the validity rule of the fetch stage
      reissue <= !started || redirect.valid;
    end
  end

  // Redirect and BTB targets come from other blocks and must stay word aligned
  a_pc_next_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    fetch_en |-> pc_next[1:0] == 2'b00)
    else $error("fetch_ctrl: misaligned pc_next %h", pc_next);

endmodule

`default_nettype wire

/* design/fetch_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_top (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    stall,
  input  fetch_pkg::redirect_t    redirect,
  input  fetch_pkg::btb_update_t  btb_upd,
  input  fetch_pkg::imem_load_t   imem_load,
  output fetch_pkg::fetch_out_t   fetch
);
  import fetch_pkg::*;

  // Early fetch address, shared by the BRAM, the BTB and the stage
  logic [XLEN-1:0] pc_next;

  // Equals ready out of reset and is also high during reset
  logic fetch_en;
  logic flush;

  // BTB answer for pc_next
  fetch_pred_t pred;

  // Registered BRAM word
  logic [31:0] imem_rdata;

  fetch_ctrl ctrl_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .stall    (stall),
    .redirect (redirect),
    .pred     (pred),
    .pc_next  (pc_next),
    .fetch_en (fetch_en),
    .flush    (flush)
  );

  imem_bram imem_i (
    .clk   (clk),
    .ren   (fetch_en),
    .raddr (pc_next),
    .rdata (imem_rdata),
    .load  (imem_load)
  );

  btb btb_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .lookup_pc (pc_next),
    .pred      (pred),
    .upd       (btb_upd)
  );

  // Stage ready shares the BRAM enable so the buffers and rdata move together
  // Reset dominates inside the stage, so the extra reset term changes nothing
  fetch_stage_bram stage_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .ready      (fetch_en),
    .flush      (flush),
    .fetch_addr (pc_next),
    .pred_in    (pred),
    .imem_rdata (imem_rdata),
    .out        (fetch)
  );

endmodule

`default_nettype wire

/* design/imem_bram.sv */
`timescale 1ns/1ps
`default_nettype none

module imem_bram (
  input  logic                        clk,
  input  logic                        ren,
  input  logic [fetch_pkg::XLEN-1:0]  raddr,
  output logic [31:0]                 rdata,
  input  fetch_pkg::imem_load_t       load
);
  import fetch_pkg::*;

  logic [31:0]        mem [IMEM_DEPTH];
  logic [IMEM_AW-1:0] ridx;

  // Word index, byte offset bits are ignored
  assign ridx = raddr[IMEM_AW+1:2];

  // Single clock, read and write ports
  // rdata only moves when ren is high, which keeps the word stable over a stall
  always_ff @(posedge clk) begin
    if (load.we) begin
      mem[load.addr] <= load.data;
    end
    if (ren) begin
      rdata <= mem[ridx];
    end
  end

  // Read-during-write returns the old word, worth a note when it happens
  a_no_rw_collision: assert property (@(posedge clk)
    !(ren && load.we && load.addr == ridx))
    else $warning("imem_bram: read and write to word %0d in one cycle", ridx);

endmodule

`default_nettype wire

/* fetch_stage/fetch_stage_bram.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_stage_bram (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        ready,
  input  logic                        flush,
  input  logic [fetch_pkg::XLEN-1:0]  fetch_addr,
  input  fetch_pkg::fetch_pred_t      pred_in,
  input  logic [31:0]                 imem_rdata,
  output fetch_pkg::fetch_out_t       out
);
  import fetch_pkg::*;

  // Address side of the slot, lined up with the BRAM output
  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] pc_plus4_q;

  // Buffered prediction for the same address
  logic            pred_hit_q;
  logic            pred_taken_q;
  logic [XLEN-1:0] pred_target_q;

  // Validity tracking
  logic started;
  logic valid_q;

  // The BRAM reads fetch_addr on the same edge these registers capture it,
  // so after the edge the address, prediction and rdata describe one slot
  // These keep tracking through a flush, only the slot's valid bit drops
  always_ff @(posedge clk) begin
    if (ready) begin
      pc_q          <= fetch_addr;
      pc_plus4_q    <= fetch_addr + XLEN'(4);
      pred_target_q <= pred_in.target;
    end
  end

  // Prediction flags are control, they start low after reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pred_hit_q   <= 1'b0;
      pred_taken_q <= 1'b0;
    end else if (ready) begin
      pred_hit_q   <= pred_in.hit;
      pred_taken_q <= pred_in.taken;
    end
  end

  // First ready edge after reset only arms started
  // The slot captured on that edge is dropped
  // A flush marks the slot captured on the same edge as empty
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      started <= 1'b0;
      valid_q <= 1'b0;
    end else if (ready) begin
      started <= 1'b1;
      valid_q <= started && !flush;
    end
  end

  // Slot assembly
  // Instruction comes straight from the BRAM register, NOP when the slot is empty
  always_comb begin
    out.valid       = valid_q;
    out.instr       = valid_q ? imem_rdata : I_NOP;
    out.pc          = pc_q;
    out.pc_plus4    = pc_plus4_q;
    out.pred.hit    = pred_hit_q;
    out.pred.taken  = pred_taken_q;
    out.pred.target = pred_target_q;
  end

  // A slot can only turn valid on an edge where the stage advanced
  a_valid_on_ready: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(out.valid) |-> $past(ready))
    else $error("fetch_stage_bram: valid rose without ready");

endmodule

`default_nettype wire

/* sim/fetch_stimulus.txt */
# L word_index data | B pc target taken | S run_cycles max_stall | J target | E pc test_id
# Addresses and data are hex, S counts and test ids are decimal
L 00 00100093
L 01 00200113
L 02 00300193
L 03 00208463
L 04 00400213
L 05 00500293
L 06 00108093
L 07 fe5ff06f
# Not-taken entry at 0x0c, taken loop back from 0x1c
B 0000000c 00000040 0
B 0000001c 00000000 1
E 00000000 1
S 7 0
E 0000001c 2
S 3 4
S 2 6
S 1 3
S 2 0
E 0000001c 3
J 00000010
S 0 3
E 00000010 4
B 00000018 00000004 1
S 2 0
E 00000004 5

/* sim/fetch_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_tb;
  import fetch_pkg::*;

  // Parsed stimulus line with op holding the letter and a to c the columns after it
  typedef struct packed {
    logic [7:0]  op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
  } cmd_t;

  logic        clk;
  logic        rst_n;
  logic        stall;
  redirect_t   redirect;
  btb_update_t btb_upd;
  imem_load_t  imem_load;
  fetch_out_t  fetch;

  // Reference model state
  cmd_t        cmds [$];
  logic [31:0] prog [IMEM_DEPTH];
  logic [31:0] btb_target [logic [31:0]];
  logic        btb_taken [logic [31:0]];
  fetch_out_t  last_fetch;
  logic [31:0] exp_pc;
  logic        model_started;

  int errors = 0;
  int test_mark = 0;
  int tests_done = 0;
  int cycles = 0;
  int cycle_limit = 0;
  int fd;

  fetch_top dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .stall     (stall),
    .redirect  (redirect),
    .btb_upd   (btb_upd),
    .imem_load (imem_load),
    .fetch     (fetch)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // The watchdog limit is set once the stimulus file has been parsed
  initial begin
    while (cycle_limit <= 0 || cycles <= cycle_limit) begin
      @(posedge clk);
      cycles = cycles + 1;
    end
    $display("Timeout after %0d cycles, the fetch stream stopped advancing", cycles);
    $display("** FAIL **");
    $finish;
  end

  task automatic flag_mismatch(input string msg);
    errors++;
    $display("Mismatch at %0t: %s", $time, msg);
  endtask

  function automatic string test_name(input int id);
    case (id)
      1: return "reset";
      2: return "sequential fetch";
      3: return "stall";
      4: return "redirect";
      5: return "prediction";
      default: return "unnamed";
    endcase
  endfunction

  // Compare a slot that should be valid with the next pc of the model
  task automatic check_valid_slot();
    logic hit;
    logic taken;
    hit = (btb_target.exists(exp_pc) != 0);
    taken = 1'b0;
    if (hit) begin
      taken = btb_taken[exp_pc];
    end
    if (fetch.valid !== 1'b1) begin
      flag_mismatch($sformatf("expected a valid slot for pc %h", exp_pc));
    end else begin
      if (fetch.pc !== exp_pc) begin
        flag_mismatch($sformatf("pc %h, expected %h", fetch.pc, exp_pc));
      end
      if (fetch.pc_plus4 !== exp_pc + 32'd4) begin
        flag_mismatch($sformatf("pc_plus4 %h at pc %h", fetch.pc_plus4, exp_pc));
      end
      if (fetch.instr !== prog[exp_pc[IMEM_AW+1:2]]) begin
        flag_mismatch($sformatf("instr %h at pc %h", fetch.instr, exp_pc));
      end
      if (fetch.pred.hit !== hit || fetch.pred.taken !== taken) begin
        flag_mismatch($sformatf("pred hit %b taken %b at pc %h, expected %b %b",
          fetch.pred.hit, fetch.pred.taken, exp_pc, hit, taken));
      end
      if (hit && fetch.pred.target !== btb_target[exp_pc]) begin
        flag_mismatch($sformatf("pred target %h at pc %h", fetch.pred.target, exp_pc));
      end
    end
    // A taken hit steers the model to the stored target
    exp_pc = taken ? btb_target[exp_pc] : exp_pc + 32'd4;
  endtask

  // Inputs seen by the edge are still on the wires when this runs
  task automatic check_slot();
    if (!rst_n) begin
      model_started = 1'b0;
      if (fetch.valid !== 1'b0 || fetch.instr !== I_NOP) begin
        flag_mismatch("slot not empty during reset");
      end
      if (fetch.pred.hit !== 1'b0 || fetch.pred.taken !== 1'b0) begin
        flag_mismatch("prediction flags set during reset");
      end
    end else if (stall) begin
      if (fetch !== last_fetch) begin
        flag_mismatch("fetch output moved during a stall");
      end
    end else if (!model_started || redirect.valid) begin
      // First ready edge and flushed edges leave an empty slot
      model_started = 1'b1;
      if (redirect.valid) begin
        exp_pc = redirect.target;
      end
      if (fetch.valid !== 1'b0 || fetch.instr !== I_NOP) begin
        flag_mismatch($sformatf("slot at pc %h should be empty", fetch.pc));
      end
    end else begin
      check_valid_slot();
    end
    last_fetch = fetch;
  endtask

  // Inputs change 1 ns after the edge, outputs are sampled at the same point
  task automatic tick();
    @(posedge clk);
    #1;
    check_slot();
  endtask

  task automatic read_stimulus(output int total);
    int r;
    logic [7:0]  op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [8*120-1:0] line;
    total = 3;
    while (!$feof(fd)) begin
      r = $fscanf(fd, " %c", op);
      if (r == 1) begin
        a = '0;
        b = '0;
        c = '0;
        case (op)
          "#": r = $fgets(line, fd);
          "L": r = $fscanf(fd, "%h %h", a, b);
          "B": r = $fscanf(fd, "%h %h %h", a, b, c);
          "S": r = $fscanf(fd, "%d %d", a, b);
          "J": r = $fscanf(fd, "%h", a);
          "E": r = $fscanf(fd, "%h %d", a, b);
          default: begin
            errors++;
            $display("Unknown command letter %c in the stimulus file", op);
          end
        endcase
        if (op != "#") begin
          cmds.push_back('{op: op, a: a, b: b, c: c});
          total += (op == "S") ? int'(a + b) : (op == "E") ? 2 : 1;
        end
      end
    end
  endtask

  task automatic run_cmd(input cmd_t cmd);
    int stall_len;
    case (cmd.op)
      "B": begin
        btb_upd.valid  = 1'b1;
        btb_upd.pc     = cmd.a;
        btb_upd.target = cmd.b;
        btb_upd.taken  = cmd.c[0];
        tick();
        btb_upd.valid = 1'b0;
        // The entry answers lookups only from the cycle after its strobe
        btb_target[cmd.a] = cmd.b;
        btb_taken[cmd.a]  = cmd.c[0];
      end
      "S": begin
        repeat (cmd.a) tick();
        if (cmd.b != 0) begin
          stall_len = 1 + int'($urandom % cmd.b);
          stall = 1'b1;
          repeat (stall_len) tick();
          stall = 1'b0;
        end
      end
      "J": begin
        redirect.valid  = 1'b1;
        redirect.target = cmd.a;
        tick();
        redirect.valid = 1'b0;
      end
      "E": begin
        while (fetch.valid !== 1'b1) tick();
        if (fetch.pc !== cmd.a) begin
          flag_mismatch($sformatf("marked slot pc %h, expected %h", fetch.pc, cmd.a));
        end
        tests_done++;
        $display("Test %0d %s finished with %0d errors", cmd.b, test_name(int'(cmd.b)),
          errors - test_mark);
        test_mark = errors;
      end
      default: begin
      end
    endcase
  endtask

  task automatic run_stimulus();
    int total;
    read_stimulus(total);
    $fclose(fd);
    cycle_limit = 2 * total + 50;
    // Program goes in while reset is held
    foreach (cmds[i]) begin
      if (cmds[i].op == "L") begin
        imem_load.we   = 1'b1;
        imem_load.addr = cmds[i].a[IMEM_AW-1:0];
        imem_load.data = cmds[i].b;
        prog[cmds[i].a[IMEM_AW-1:0]] = cmds[i].b;
        tick();
      end
    end
    imem_load.we = 1'b0;
    repeat (2) tick();
    rst_n = 1'b1;
    foreach (cmds[i]) begin
      run_cmd(cmds[i]);
    end
    $display("Tests finished: %0d, errors: %0d", tests_done, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  endtask

  initial begin
    rst_n = 1'b0;
    stall = 1'b0;
    redirect = '0;
    btb_upd = '0;
    imem_load = '0;
    exp_pc = RESET_PC;
    model_started = 1'b0;
    void'($urandom(32'h8e6254d7));
    fd = $fopen("sim/fetch_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file sim/fetch_stimulus.txt");
      $display("** FAIL **");
      $finish;
    end else begin
      run_stimulus();
    end
  end

endmodule

`default_nettype wire

/* vlog.f */
common/fetch_pkg.sv
design/fetch_ctrl.sv
design/imem_bram.sv
design/btb.sv
fetch_stage/fetch_stage_bram.sv
design/fetch_top.sv
sim/fetch_tb.sv
